// ==== hw/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetPc = 32'hBFC0_0000;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0A;
    localparam logic [5:0] opAndi    = 6'h0C;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opXori    = 6'h0E;
    localparam logic [5:0] opLui     = 6'h0F;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2B;

    // SPECIAL function field
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2A;
    localparam logic [5:0] fnSltu = 6'h2B;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluLui
    } aluOpT;

    // operand source for execute
    typedef enum logic [1:0] {
        selReg,
        selMem,
        selWb
    } fwdSelT;

    typedef struct packed {
        aluOpT aluOp;
        logic  immSel;   // operand B is the immediate
        logic  signExt;
        logic  regWen;
        logic  memRead;
        logic  memWrite;
        logic  dstRd;    // else rt
    } decodedCtrlT;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    rsVal;
        logic [dataWidth-1:0]    rtVal;
        logic [dataWidth-1:0]    imm;
        decodedCtrlT             ctrl;
    } idExT;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    aluRes;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] dst;
        logic                    regWen;
        logic                    memRead;
        logic                    memWrite;
    } exMemT;

    typedef struct packed {
        logic [regAddrWidth-1:0] dst;
        logic                    regWen;
        logic [dataWidth-1:0]    result;
    } memWbT;

endpackage

`default_nettype wire

// ==== hw/hazardIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazardIf import mipsPkg::*; ();

    logic   stallF;
    logic   stallD;
    logic   stallE;
    logic   stallM;
    logic   flushE;
    fwdSelT fwdA;   // rs operand in execute
    fwdSelT fwdB;   // rt operand in execute

    modport unit (
        output stallF, stallD, stallE, stallM, flushE, fwdA, fwdB
    );

    modport pipe (
        input stallF, stallD, stallE, stallM, flushE, fwdA, fwdB
    );

endinterface

`default_nettype wire

// ==== hw/pipeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // a cleared payload is a bubble
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic [regAddrWidth-1:0] raddrA,
    input  logic [regAddrWidth-1:0] raddrB,
    input  logic [regAddrWidth-1:0] waddr,
    input  logic                    wen,
    input  logic [dataWidth-1:0]    wdata,
    output logic [dataWidth-1:0]    rdataA,
    output logic [dataWidth-1:0]    rdataB
);

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 reads zero, commit in flight is passed through
    assign rdataA = (raddrA == '0) ? '0 :
                    (wen && waddr == raddrA) ? wdata : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 :
                    (wen && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import mipsPkg::*; (
    input  logic [dataWidth-1:0] instr,
    output decodedCtrlT          ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;  // no-op unless recognized
        case (opcode)
            opSpecial: begin
                ctrl.regWen = 1'b1;
                ctrl.dstRd  = 1'b1;
                case (funct)
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnNor:   ctrl.aluOp = aluNor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSltu:  ctrl.aluOp = aluSltu;
                    default: ctrl = '0;  // includes the all-zero word
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
                ctrl.immSel = 1'b1;
                ctrl.regWen = 1'b1;
                case (opcode)
                    opAddiu: ctrl.aluOp = aluAdd;
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluLui;
                endcase
                ctrl.signExt = (opcode == opAddiu) || (opcode == opSlti);
            end
            opLw: begin
                ctrl.immSel  = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.regWen  = 1'b1;
                ctrl.memRead = 1'b1;
            end
            opSw: begin
                ctrl.immSel   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.memWrite = 1'b1;   // address only, rt is the data
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit import mipsPkg::*; (
    input  idExT                 ex,
    input  logic [dataWidth-1:0] fwdMem,
    input  logic [dataWidth-1:0] fwdWb,
    hazardIf.pipe                hz,
    output exMemT                out
);

    logic [dataWidth-1:0]    rsVal;
    logic [dataWidth-1:0]    rtVal;
    logic [dataWidth-1:0]    srcB;
    logic [dataWidth-1:0]    aluRes;
    logic [regAddrWidth-1:0] dst;

    function automatic logic [dataWidth-1:0] pickOperand(
        input fwdSelT               sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            selMem:  return memVal;
            selWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign rsVal = pickOperand(hz.fwdA, ex.rsVal, fwdMem, fwdWb);
    assign rtVal = pickOperand(hz.fwdB, ex.rtVal, fwdMem, fwdWb);
    assign srcB  = ex.ctrl.immSel ? ex.imm : rtVal;
    assign dst   = ex.ctrl.dstRd ? ex.rd : ex.rt;

    always_comb begin
        case (ex.ctrl.aluOp)
            aluAdd:  aluRes = rsVal + srcB;
            aluSub:  aluRes = rsVal - srcB;
            aluAnd:  aluRes = rsVal & srcB;
            aluOr:   aluRes = rsVal | srcB;
            aluXor:  aluRes = rsVal ^ srcB;
            aluNor:  aluRes = ~(rsVal | srcB);
            aluSlt:  aluRes = {{(dataWidth-1){1'b0}}, $signed(rsVal) < $signed(srcB)};
            aluSltu: aluRes = {{(dataWidth-1){1'b0}}, rsVal < srcB};
            aluLui:  aluRes = {srcB[15:0], 16'h0000};
            default: aluRes = '0;
        endcase
    end

    always_comb begin
        out.pc        = ex.pc;
        out.aluRes    = aluRes;
        out.storeData = rtVal;
        out.dst       = dst;
        out.regWen    = ex.ctrl.regWen && (dst != '0);  // $0 writes dropped here
        out.memRead   = ex.ctrl.memRead;
        out.memWrite  = ex.ctrl.memWrite;
    end

endmodule

`default_nettype wire

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
    hazardIf.unit                  hz,
    input  logic                    dStall,
    input  logic                    iStall,
    input  logic [regAddrWidth-1:0] rsD,
    input  logic [regAddrWidth-1:0] rtD,
    input  logic [regAddrWidth-1:0] rsE,
    input  logic [regAddrWidth-1:0] rtE,
    input  logic [regAddrWidth-1:0] dstE,
    input  logic                    wenE,
    input  logic                    loadE,
    input  logic [regAddrWidth-1:0] dstM,
    input  logic                    wenM,
    input  logic [regAddrWidth-1:0] dstW,
    input  logic                    wenW
);

    logic loadUse;

    function automatic fwdSelT pickSource(
        input logic [regAddrWidth-1:0] src,
        input logic [regAddrWidth-1:0] memDst,
        input logic                    memWen,
        input logic [regAddrWidth-1:0] wbDst,
        input logic                    wbWen
    );
        if (src == '0) return selReg;
        if (memWen && memDst == src) return selMem;  // youngest value wins
        if (wbWen && wbDst == src) return selWb;
        return selReg;
    endfunction

    // load result only exists in the memory stage
    assign loadUse = loadE && wenE && (dstE == rsD || dstE == rtD);

    always_comb begin
        hz.stallF = dStall || loadUse || iStall;
        hz.stallD = dStall || loadUse;
        hz.stallE = dStall;
        hz.stallM = dStall;
        hz.flushE = loadUse && !dStall;
        hz.fwdA   = pickSource(rsE, dstM, wenM, dstW, wenW);
        hz.fwdB   = pickSource(rtE, dstM, wenM, dstW, wenW);
    end

endmodule

`default_nettype wire

// ==== hw/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    output logic                    instrEn,
    output logic [dataWidth-1:0]    pcF,
    input  logic [dataWidth-1:0]    instr,
    input  logic                    iStall,
    input  logic                    dStall,
    output logic                    memEn,
    output logic [dataWidth-1:0]    memAddr,
    output logic [3:0]              memWen,
    output logic [dataWidth-1:0]    memWdata,
    input  logic [dataWidth-1:0]    memRdata,
    output logic [dataWidth-1:0]    debugWbPc,
    output logic [3:0]              debugWbRfWen,
    output logic [regAddrWidth-1:0] debugWbRfWnum,
    output logic [dataWidth-1:0]    debugWbRfWdata
);

    logic                    running;
    ifIdT                    ifIdD;
    ifIdT                    ifIdQ;
    idExT                    idExD;
    idExT                    idExQ;
    exMemT                   exMemD;
    exMemT                   exMemQ;
    memWbT                   memWbD;
    memWbT                   memWbQ;
    decodedCtrlT             ctrlD;
    logic [regAddrWidth-1:0] rsD;
    logic [regAddrWidth-1:0] rtD;
    logic [dataWidth-1:0]    rsValD;
    logic [dataWidth-1:0]    rtValD;
    logic [dataWidth-1:0]    resultM;

    hazardIf hz ();

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            pcF     <= resetPc;
        end else begin
            running <= 1'b1;    // first fetch one cycle after release
            if (instrEn) begin
                pcF <= pcF + 32'd4;
            end
        end
    end

    assign instrEn = running && !hz.stallF;
    assign ifIdD   = instrEn ? ifIdT'{pc: pcF, instr: instr} : '0;  // bubble when held

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN(rstN), .stall(hz.stallD), .flush(1'b0), .d(ifIdD), .q(ifIdQ)
    );

    assign rsD = ifIdQ.instr[25:21];
    assign rtD = ifIdQ.instr[20:16];

    instrDecoder decoder (.instr(ifIdQ.instr), .ctrl(ctrlD));

    // commit happens in memory stage
    regFile rf (
        .clk(clk),
        .raddrA(rsD),
        .raddrB(rtD),
        .waddr(exMemQ.dst),
        .wen(exMemQ.regWen && !hz.stallM),
        .wdata(resultM),
        .rdataA(rsValD),
        .rdataB(rtValD)
    );

    always_comb begin
        idExD.pc    = ifIdQ.pc;
        idExD.rs    = rsD;
        idExD.rt    = rtD;
        idExD.rd    = ifIdQ.instr[15:11];
        idExD.rsVal = rsValD;
        idExD.rtVal = rtValD;
        idExD.imm   = {{(dataWidth-16){ctrlD.signExt & ifIdQ.instr[15]}}, ifIdQ.instr[15:0]};
        idExD.ctrl  = ctrlD;
    end

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN(rstN), .stall(hz.stallE), .flush(hz.flushE), .d(idExD), .q(idExQ)
    );

    executeUnit exec (
        .ex(idExQ), .fwdMem(exMemQ.aluRes), .fwdWb(memWbQ.result), .hz(hz), .out(exMemD)
    );

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN(rstN), .stall(hz.stallM), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    assign resultM  = exMemQ.memRead ? memRdata : exMemQ.aluRes;
    assign memEn    = exMemQ.memRead || exMemQ.memWrite;   // held through dStall
    assign memAddr  = exMemQ.aluRes;
    assign memWen   = {4{exMemQ.memWrite}};
    assign memWdata = exMemQ.storeData;

    assign memWbD = memWbT'{dst: exMemQ.dst, regWen: exMemQ.regWen, result: resultM};

    // result register, forwarding source only
    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN(rstN), .stall(hz.stallM), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    assign debugWbPc      = exMemQ.pc;
    assign debugWbRfWen   = {4{exMemQ.regWen && !hz.stallM}};
    assign debugWbRfWnum  = exMemQ.dst;
    assign debugWbRfWdata = resultM;

    hazardUnit hazard (
        .hz(hz),
        .dStall(dStall),
        .iStall(iStall),
        .rsD(rsD),
        .rtD(rtD),
        .rsE(idExQ.rs),
        .rtE(idExQ.rt),
        .dstE(exMemD.dst),
        .wenE(exMemD.regWen),
        .loadE(exMemD.memRead),
        .dstM(exMemQ.dst),
        .wenM(exMemQ.regWen),
        .dstW(memWbQ.dst),
        .wenW(memWbQ.regWen)
    );

endmodule

`default_nettype wire

// ==== tests/mipsCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

    localparam int progWords     = 128;
    localparam int memWords      = 64;
    localparam int timeoutCycles = 3000;

    logic        clk;
    logic        rstN;
    logic        instrEn;
    logic [31:0] pcF;
    logic [31:0] instr;
    logic        iStall;
    logic        dStall;
    logic        memEn;
    logic [31:0] memAddr;
    logic [3:0]  memWen;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic [31:0] debugWbPc;
    logic [3:0]  debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [progWords];
    logic [31:0] dmem [memWords];
    logic [31:0] refMem [memWords];
    logic [31:0] refRegs [32];
    logic [31:0] lfsr = 32'd99268;

    // expected commits and stores in program order
    logic [31:0] expPc [$];
    logic [4:0]  expReg [$];
    logic [31:0] expVal [$];
    logic [31:0] expStAddr [$];
    logic [31:0] expStData [$];

    int valueErrors = 0;
    int otherErrors = 0;
    bit fetchSeen = 1'b0;
    bit rstPrev = 1'b0;

    mipsCore mipsCore_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = randBits(3);
        return (r[2:0] == 3'd0) ? 5'd7 : {2'b00, r[2:0]};  // registers 1 to 7
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        return (32'h9E37_79B9 * 32'(i + 1)) ^ 32'(i << 12);
    endfunction

    function automatic logic [31:0] fetchWord(input logic [31:0] pc);
        logic [31:0] idx;
        idx = (pc - resetPc) >> 2;
        return (idx < progWords) ? imem[idx[6:0]] : 32'd0;
    endfunction

    task automatic buildProgram();
        logic [31:0] kind;
        logic [31:0] sel;
        logic [31:0] r;
        logic [4:0]  rt;
        logic [5:0]  fn;
        logic [5:0]  op;
        int          n;
        n = 0;
        for (int i = 0; i < progWords; i++) begin
            imem[i] = '0;
        end
        // every register gets a known value first
        for (int i = 1; i < 8; i++) begin
            r = randBits(16);
            imem[n] = {opAddiu, 5'd0, 5'(i), r[15:0]};
            n++;
        end
        while (n < 67) begin
            kind = randBits(4);
            if (kind < 8) begin
                sel = randBits(3);
                case (sel[2:0])
                    3'd0: fn = fnAddu;
                    3'd1: fn = fnSubu;
                    3'd2: fn = fnAnd;
                    3'd3: fn = fnOr;
                    3'd4: fn = fnXor;
                    3'd5: fn = fnNor;
                    3'd6: fn = fnSlt;
                    default: fn = fnSltu;
                endcase
                imem[n] = {opSpecial, pickReg(), pickReg(), pickReg(), 5'd0, fn};
            end else if (kind < 13) begin
                sel = randBits(3) % 6;
                r   = randBits(16);
                case (sel)
                    0: op = opAddiu;
                    1: op = opSlti;
                    2: op = opAndi;
                    3: op = opOri;
                    4: op = opXori;
                    default: op = opLui;
                endcase
                if (op == opLui) begin
                    imem[n] = {op, 5'd0, pickReg(), r[15:0]};
                end else begin
                    imem[n] = {op, pickReg(), pickReg(), r[15:0]};
                end
            end else begin
                r  = randBits(6);
                rt = pickReg();
                op = (kind == 14) ? opSw : opLw;
                imem[n] = {op, 5'd0, rt, 8'd0, r[5:0], 2'b00};
                if (kind == 15) begin     // load-use pair
                    n++;
                    imem[n] = {opSpecial, rt, pickReg(), pickReg(), 5'd0, fnAddu};
                end
            end
            n++;
        end
    endtask

    // in-order ISA model of the whole program image
    function automatic void runReference();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] addr;
        logic [4:0]  dst;
        bit          wr;
        for (int i = 0; i < progWords; i++) begin
            w    = imem[i];
            a    = refRegs[w[25:21]];
            b    = refRegs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            zimm = {16'h0000, w[15:0]};
            addr = a + simm;
            dst  = w[20:16];
            v    = '0;
            wr   = 1'b1;
            case (w[31:26])
                opSpecial: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fnAddu:  v = a + b;
                        fnSubu:  v = a - b;
                        fnAnd:   v = a & b;
                        fnOr:    v = a | b;
                        fnXor:   v = a ^ b;
                        fnNor:   v = ~(a | b);
                        fnSlt:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu:  v = (a < b) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;  // nop word lands here
                    endcase
                end
                opAddiu: v = a + simm;
                opSlti:  v = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                opAndi:  v = a & zimm;
                opOri:   v = a | zimm;
                opXori:  v = a ^ zimm;
                opLui:   v = {w[15:0], 16'h0000};
                opLw:    v = refMem[addr[7:2]];
                opSw: begin
                    refMem[addr[7:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                refRegs[dst] = v;
                expPc.push_back(resetPc + 32'(i) * 32'd4);
                expReg.push_back(dst);
                expVal.push_back(v);
            end
        end
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    // memories and random stall levels
    always @(negedge clk) begin
        logic [31:0] r;
        instr    = fetchWord(pcF);
        memRdata = memEn ? dmem[memAddr[7:2]] : '0;
        r = randBits(2);
        iStall = &r[1:0];
        r = randBits(2);
        dStall = &r[1:0];
    end

    always @(posedge clk) begin
        if (memEn && memWen == 4'hF && !dStall) begin
            dmem[memAddr[7:2]] = memWdata;
        end
    end

    always @(posedge clk) begin
        if (!rstN || !rstPrev) begin
            assert (!instrEn && !memEn && debugWbRfWen == 4'h0) else begin
                $display("enables were not low during or right after reset at %0t", $time);
                otherErrors++;
            end
        end
        rstPrev = rstN;
        if (instrEn && !fetchSeen) begin
            fetchSeen = 1'b1;
            checkWord("pcF", pcF, resetPc);
        end
        if (debugWbRfWen != 4'h0) begin
            assert (!dStall) else begin
                $display("register write reported while dStall was high at %0t", $time);
                otherErrors++;
            end
            assert (expPc.size() > 0) else begin
                $display("register write at %0t with no commit left to match", $time);
                otherErrors++;
            end
            if (expPc.size() > 0) begin
                checkWord("debugWbPc", debugWbPc, expPc.pop_front());
                checkWord("debugWbRfWnum", {27'd0, debugWbRfWnum}, {27'd0, expReg.pop_front()});
                checkWord("debugWbRfWdata", debugWbRfWdata, expVal.pop_front());
                checkWord("debugWbRfWen", {28'd0, debugWbRfWen}, 32'hF);
            end
        end
        if (memEn && memWen != 4'h0 && !dStall) begin
            assert (expStAddr.size() > 0) else begin
                $display("store at %0t with no store left to match", $time);
                otherErrors++;
            end
            if (expStAddr.size() > 0) begin
                checkWord("memAddr", memAddr, expStAddr.pop_front());
                checkWord("memWdata", memWdata, expStData.pop_front());
                checkWord("memWen", {28'd0, memWen}, 32'hF);
            end
        end
    end

    initial begin
        int cycles;
        rstN     = 1'b0;
        iStall   = 1'b0;
        dStall   = 1'b0;
        instr    = '0;
        memRdata = '0;
        for (int i = 0; i < memWords; i++) begin
            dmem[i]   = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        buildProgram();
        runReference();
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        cycles = 0;
        while ((expPc.size() > 0 || expStAddr.size() > 0) && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (expPc.size() == 0 && expStAddr.size() == 0) else begin
            $display("timed out with %0d commits and %0d stores outstanding",
                     expPc.size(), expStAddr.size());
            otherErrors++;
        end
        // trailing zero words must stay silent
        cycles = 0;
        while (cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (fetchSeen) else begin
            $display("no fetch was ever issued");
            otherErrors++;
        end

        $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/mipsPkg.sv
hw/hazardIf.sv
hw/pipeReg.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/executeUnit.sv
hw/hazardUnit.sv
hw/mipsCore.sv
tests/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module mipsCoreTb -Mdir obj_dir

out=$(./obj_dir/VmipsCoreTb)
echo "$out"

# pass only if the pass line was printed
echo "$out" | grep -qx "Simulation completed successfully"
